// File: compile.f
lq_pkg.sv
lq_alloc_if.sv
lq_entry_if.sv
lq_alloc.sv
lq_rr_arbiter.sv
lq_entries.sv
lq_cache_port.sv
lq_writeback.sv
load_queue.sv
load_queue_properties.sv
tb_load_queue.sv

// File: load_queue.sv
`timescale 1ns/1ps

module load_queue (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic [lq_pkg::ways-1:0]                     ld_en,
    input  lq_pkg::ld_size_t [lq_pkg::ways-1:0]         ld_size,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_w-1:0]  ld_rob,
    input  logic [lq_pkg::ways-1:0][lq_pkg::prf_w-1:0]  ld_prf,
    input  logic [lq_pkg::ways-1:0]                     ld_signed,
    input  logic [lq_pkg::ways-1:0]                     alu_valid,
    input  logic [lq_pkg::ways-1:0]                     alu_is_ls,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_w-1:0]  alu_rob,
    input  logic [lq_pkg::ways-1:0][lq_pkg::addr_w-1:0] alu_data,
    input  logic                                        dc_hit,
    input  logic [lq_pkg::data_w-1:0]                   dc_data,
    input  logic [lq_pkg::lq_depth-1:0]                 mem_feedback,
    input  logic [lq_pkg::data_w-1:0]                   mem_data,
    output logic [lq_pkg::cnt_w-1:0]                    lq_num_free,
    output logic                                        rd_en,
    output logic [lq_pkg::lq_depth-1:0]                 rd_gnt,
    output logic [lq_pkg::tag_w-1:0]                    rd_tag,
    output logic [lq_pkg::index_w-1:0]                  rd_idx,
    output logic [lq_pkg::offset_w-1:0]                 rd_offset,
    output lq_pkg::ld_size_t                            rd_size,
    output logic                                        cdb_valid,
    output logic [lq_pkg::data_w-1:0]                   cdb_data,
    output logic [lq_pkg::prf_w-1:0]                    cdb_prf,
    output logic [lq_pkg::rob_w-1:0]                    cdb_rob
);
    import lq_pkg::*;

    logic [lq_depth-1:0] free;

    lq_alloc_if alloc_bus ();
    lq_entry_if ent_bus ();

    lq_alloc u_alloc (
        .free      (free),
        .ld_en     (ld_en),
        .ld_size   (ld_size),
        .ld_rob    (ld_rob),
        .ld_prf    (ld_prf),
        .ld_signed (ld_signed),
        .alloc     (alloc_bus.producer)
    );

    lq_entries u_entries (
        .clock        (clock),
        .rst_n        (rst_n),
        .alloc        (alloc_bus.buffer),
        .alu_valid    (alu_valid),
        .alu_is_ls    (alu_is_ls),
        .alu_rob      (alu_rob),
        .alu_data     (alu_data),
        .dc_hit       (dc_hit),
        .dc_data      (dc_data),
        .mem_feedback (mem_feedback),
        .mem_data     (mem_data),
        .ent          (ent_bus.buffer),
        .free         (free),
        .lq_num_free  (lq_num_free)
    );

    lq_cache_port u_cache_port (
        .clock     (clock),
        .rst_n     (rst_n),
        .ent       (ent_bus.cache_port),
        .rd_en     (rd_en),
        .rd_gnt    (rd_gnt),
        .rd_tag    (rd_tag),
        .rd_idx    (rd_idx),
        .rd_offset (rd_offset),
        .rd_size   (rd_size)
    );

    lq_writeback u_writeback (
        .clock     (clock),
        .rst_n     (rst_n),
        .ent       (ent_bus.writeback),
        .cdb_valid (cdb_valid),
        .cdb_data  (cdb_data),
        .cdb_prf   (cdb_prf),
        .cdb_rob   (cdb_rob)
    );

endmodule

// File: load_queue_properties.sv
`timescale 1ns/1ps

module load_queue_properties (
    input logic                        clock,
    input logic                        rst_n,
    input logic                        rd_en,
    input logic [lq_pkg::lq_depth-1:0] rd_gnt,
    input logic                        cdb_valid,
    input logic [lq_pkg::cnt_w-1:0]    lq_num_free
);
    import lq_pkg::*;

    // at most one entry reads the cache per cycle
    gnt_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(rd_gnt))
        else $error("rd_gnt has more than one bit set");

    rd_en_match: assert property (@(posedge clock) disable iff (!rst_n) rd_en == (|rd_gnt))
        else $error("rd_en disagrees with rd_gnt");

    cdb_known: assert property (@(posedge clock) disable iff (!rst_n) !$isunknown(cdb_valid))
        else $error("cdb_valid is unknown");

    free_bound: assert property (@(posedge clock) disable iff (!rst_n)
        lq_num_free <= cnt_w'(lq_depth))
        else $error("lq_num_free exceeds the queue depth");

endmodule

bind load_queue load_queue_properties props (
    .clock       (clock),
    .rst_n       (rst_n),
    .rd_en       (rd_en),
    .rd_gnt      (rd_gnt),
    .cdb_valid   (cdb_valid),
    .lq_num_free (lq_num_free)
);

// File: lq_alloc.sv
`timescale 1ns/1ps

module lq_alloc (
    input  logic [lq_pkg::lq_depth-1:0]                free,
    input  logic [lq_pkg::ways-1:0]                    ld_en,
    input  lq_pkg::ld_size_t [lq_pkg::ways-1:0]        ld_size,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_w-1:0] ld_rob,
    input  logic [lq_pkg::ways-1:0][lq_pkg::prf_w-1:0] ld_prf,
    input  logic [lq_pkg::ways-1:0]                    ld_signed,
    lq_alloc_if.producer                               alloc
);
    import lq_pkg::*;

    logic [lq_depth-1:0] lowest;
    logic [lq_depth-1:0] highest;
    logic [lq_depth-1:0] gnt0;
    logic [lq_depth-1:0] gnt1;

    // way 0 takes the lowest free entry
    assign lowest = free & (~free + 1'b1);
    assign gnt0   = ld_en[0] ? lowest : '0;

    // way 1 scans upward, so the last hit is the highest one left
    always_comb begin
        highest = '0;
        for (int i = 0; i < lq_depth; i++) begin
            if (free[i] && !gnt0[i]) begin
                highest    = '0;
                highest[i] = 1'b1;
            end
        end
    end

    assign gnt1 = ld_en[1] ? highest : '0;

    // steer each way's fields to its entry
    always_comb begin
        alloc.wr_en = gnt0 | gnt1;
        for (int e = 0; e < lq_depth; e++) begin
            alloc.wr_size[e]   = sz_byte;
            alloc.wr_rob[e]    = '0;
            alloc.wr_prf[e]    = '0;
            alloc.wr_signed[e] = 1'b0;
            if (gnt0[e]) begin
                alloc.wr_size[e]   = ld_size[0];
                alloc.wr_rob[e]    = ld_rob[0];
                alloc.wr_prf[e]    = ld_prf[0];
                alloc.wr_signed[e] = ld_signed[0];
            end else if (gnt1[e]) begin
                alloc.wr_size[e]   = ld_size[1];
                alloc.wr_rob[e]    = ld_rob[1];
                alloc.wr_prf[e]    = ld_prf[1];
                alloc.wr_signed[e] = ld_signed[1];
            end
        end
    end

endmodule

// File: lq_alloc_if.sv
`timescale 1ns/1ps

interface lq_alloc_if;
    import lq_pkg::*;

    // one write strobe and one field set per entry
    logic [lq_depth-1:0]            wr_en;
    ld_size_t [lq_depth-1:0]        wr_size;
    logic [lq_depth-1:0][rob_w-1:0] wr_rob;
    logic [lq_depth-1:0][prf_w-1:0] wr_prf;
    logic [lq_depth-1:0]            wr_signed;

    modport producer (
        output wr_en, wr_size, wr_rob, wr_prf, wr_signed
    );

    modport buffer (
        input wr_en, wr_size, wr_rob, wr_prf, wr_signed
    );

endinterface

// File: lq_cache_port.sv
`timescale 1ns/1ps

module lq_cache_port (
    input  logic                          clock,
    input  logic                          rst_n,
    lq_entry_if.cache_port                ent,
    output logic                          rd_en,
    output logic [lq_pkg::lq_depth-1:0]   rd_gnt,
    output logic [lq_pkg::tag_w-1:0]      rd_tag,
    output logic [lq_pkg::index_w-1:0]    rd_idx,
    output logic [lq_pkg::offset_w-1:0]   rd_offset,
    output lq_pkg::ld_size_t              rd_size
);
    import lq_pkg::*;

    logic [lq_depth-1:0] gnt;
    ld_addr_u            sel;

    lq_rr_arbiter u_arb (
        .clock (clock),
        .rst_n (rst_n),
        .req   (ent.ready),
        .gnt   (gnt)
    );

    assign ent.cache_gnt = gnt;
    assign rd_gnt        = gnt;
    assign rd_en         = |gnt;

    // granted entry's address, zero when idle
    always_comb begin
        sel.raw = '0;
        rd_size = sz_byte;
        for (int e = 0; e < lq_depth; e++) begin
            if (gnt[e]) begin
                sel.raw = ent.addr[e];
                rd_size = ent.size[e];
            end
        end
    end

    assign rd_tag    = sel.fields.tag;
    assign rd_idx    = sel.fields.index;
    assign rd_offset = sel.fields.offset;

endmodule

// File: lq_entries.sv
`timescale 1ns/1ps

module lq_entries (
    input  logic                                        clock,
    input  logic                                        rst_n,
    lq_alloc_if.buffer                                  alloc,
    input  logic [lq_pkg::ways-1:0]                     alu_valid,
    input  logic [lq_pkg::ways-1:0]                     alu_is_ls,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_w-1:0]  alu_rob,
    input  logic [lq_pkg::ways-1:0][lq_pkg::addr_w-1:0] alu_data,
    input  logic                                        dc_hit,
    input  logic [lq_pkg::data_w-1:0]                   dc_data,
    input  logic [lq_pkg::lq_depth-1:0]                 mem_feedback,
    input  logic [lq_pkg::data_w-1:0]                   mem_data,
    lq_entry_if.buffer                                  ent,
    output logic [lq_pkg::lq_depth-1:0]                 free,
    output logic [lq_pkg::cnt_w-1:0]                    lq_num_free
);
    import lq_pkg::*;

    ld_state_t [lq_depth-1:0]        state;
    ld_size_t [lq_depth-1:0]         size_q;
    logic [lq_depth-1:0][rob_w-1:0]  rob_q;
    logic [lq_depth-1:0][prf_w-1:0]  prf_q;
    logic [lq_depth-1:0]             signed_q;
    logic [lq_depth-1:0][addr_w-1:0] addr_q;
    logic [lq_depth-1:0][data_w-1:0] data_q;
    logic [lq_depth-1:0]             addr_hit;
    logic [lq_depth-1:0][addr_w-1:0] addr_in;
    logic [cnt_w-1:0]                n_alloc;
    logic [cnt_w-1:0]                free_cnt;
    logic [cnt_w-1:0]                free_cnt_next;

    // snoop ALU results for entries still missing an address
    always_comb begin
        addr_hit = '0;
        addr_in  = '0;
        for (int w = 0; w < ways; w++) begin
            for (int e = 0; e < lq_depth; e++) begin
                if (alu_valid[w] && alu_is_ls[w] && !free[e] &&
                    state[e] == st_addr && alu_rob[w] == rob_q[e]) begin
                    addr_hit[e] = 1'b1;
                    addr_in[e]  = alu_data[w];
                end
            end
        end
    end

    // at most one broadcast per cycle
    assign n_alloc       = cnt_w'($countones(alloc.wr_en));
    assign free_cnt_next = free_cnt - n_alloc + cnt_w'(|ent.cdb_gnt);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            free        <= '1;
            free_cnt    <= cnt_w'(lq_depth);
            lq_num_free <= cnt_w'(lq_depth);
            for (int e = 0; e < lq_depth; e++) begin
                state[e] <= st_addr;
            end
        end else begin
            free        <= (free | ent.cdb_gnt) & ~alloc.wr_en;
            free_cnt    <= free_cnt_next;
            // report zero once a full dispatch group would not fit
            lq_num_free <= (free_cnt_next < cnt_w'(ways)) ? '0 : free_cnt_next;
            for (int e = 0; e < lq_depth; e++) begin
                if (alloc.wr_en[e]) begin
                    state[e] <= st_addr;
                end else begin
                    case (state[e])
                        st_addr:  if (addr_hit[e]) state[e] <= st_ready;
                        st_ready: if (ent.cache_gnt[e]) state[e] <= dc_hit ? st_done : st_miss;
                        st_miss:  if (mem_feedback[e]) state[e] <= st_done;
                        st_done:  if (ent.cdb_gnt[e]) state[e] <= st_addr;
                        default:  state[e] <= st_addr;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int e = 0; e < lq_depth; e++) begin
            if (alloc.wr_en[e]) begin
                size_q[e]   <= alloc.wr_size[e];
                rob_q[e]    <= alloc.wr_rob[e];
                prf_q[e]    <= alloc.wr_prf[e];
                signed_q[e] <= alloc.wr_signed[e];
            end
            if (addr_hit[e]) begin
                addr_q[e] <= addr_in[e];
            end
            // hit data now, or fill data while parked in st_miss
            if (ent.cache_gnt[e] && dc_hit) begin
                data_q[e] <= dc_data;
            end else if (state[e] == st_miss && mem_feedback[e]) begin
                data_q[e] <= mem_data;
            end
        end
    end

    always_comb begin
        for (int e = 0; e < lq_depth; e++) begin
            ent.ready[e] = (state[e] == st_ready);
            ent.done[e]  = (state[e] == st_done);
        end
    end

    assign ent.addr      = addr_q;
    assign ent.size      = size_q;
    assign ent.data      = data_q;
    assign ent.rob       = rob_q;
    assign ent.prf       = prf_q;
    assign ent.is_signed = signed_q;

endmodule

// File: lq_entry_if.sv
`timescale 1ns/1ps

interface lq_entry_if;
    import lq_pkg::*;

    // entry view, driven by the array
    logic [lq_depth-1:0]             ready;
    logic [lq_depth-1:0]             done;
    logic [lq_depth-1:0][addr_w-1:0] addr;
    ld_size_t [lq_depth-1:0]         size;
    logic [lq_depth-1:0][data_w-1:0] data;
    logic [lq_depth-1:0][rob_w-1:0]  rob;
    logic [lq_depth-1:0][prf_w-1:0]  prf;
    logic [lq_depth-1:0]             is_signed;

    // one-hot or zero, same cycle as the request
    logic [lq_depth-1:0]             cache_gnt;
    logic [lq_depth-1:0]             cdb_gnt;

    modport buffer (
        output ready, done, addr, size, data, rob, prf, is_signed,
        input  cache_gnt, cdb_gnt
    );

    modport cache_port (
        input  ready, addr, size,
        output cache_gnt
    );

    modport writeback (
        input  done, data, size, rob, prf, is_signed,
        output cdb_gnt
    );

endinterface

// File: lq_pkg.sv
package lq_pkg;

    // queue geometry
    localparam int ways     = 2;
    localparam int lq_depth = 8;
    localparam int lq_idx_w = 3;
    localparam int cnt_w    = 4;

    // core-side index widths
    localparam int rob_w    = 5;
    localparam int prf_w    = 6;
    localparam int addr_w   = 16;
    localparam int data_w   = 32;

    // dcache address split
    localparam int tag_w    = 8;
    localparam int index_w  = 5;
    localparam int offset_w = 3;

    typedef enum logic [1:0] {
        sz_byte = 2'b00,
        sz_half = 2'b01,
        sz_word = 2'b10
    } ld_size_t;

    typedef enum logic [1:0] {
        st_addr  = 2'b00,
        st_ready = 2'b01,
        st_miss  = 2'b10,
        st_done  = 2'b11
    } ld_state_t;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } ld_addr_fields_t;

    // same 16 bits, flat or as cache fields
    typedef union packed {
        logic [addr_w-1:0] raw;
        ld_addr_fields_t   fields;
    } ld_addr_u;

endpackage

// File: lq_rr_arbiter.sv
`timescale 1ns/1ps

module lq_rr_arbiter (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [lq_pkg::lq_depth-1:0]   req,
    output logic [lq_pkg::lq_depth-1:0]   gnt
);
    import lq_pkg::*;

    logic [lq_idx_w-1:0] ptr;
    logic [lq_idx_w-1:0] gnt_idx;
    logic [lq_idx_w-1:0] probe;
    logic                found;

    // first requester at or after ptr, wrapping
    always_comb begin
        gnt     = '0;
        gnt_idx = '0;
        found   = 1'b0;
        probe   = '0;
        for (int i = 0; i < lq_depth; i++) begin
            probe = lq_idx_w'(ptr + i);
            if (!found && req[probe]) begin
                found        = 1'b1;
                gnt_idx      = probe;
                gnt[probe]   = 1'b1;
            end
        end
    end

    // next search starts just past the winner
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= gnt_idx + 1'b1;
        end
    end

endmodule

// File: lq_writeback.sv
`timescale 1ns/1ps

module lq_writeback (
    input  logic                          clock,
    input  logic                          rst_n,
    lq_entry_if.writeback                 ent,
    output logic                          cdb_valid,
    output logic [lq_pkg::data_w-1:0]     cdb_data,
    output logic [lq_pkg::prf_w-1:0]      cdb_prf,
    output logic [lq_pkg::rob_w-1:0]      cdb_rob
);
    import lq_pkg::*;

    logic [lq_depth-1:0] gnt;
    logic [data_w-1:0]   raw;
    ld_size_t            size;
    logic                is_signed;

    lq_rr_arbiter u_arb (
        .clock (clock),
        .rst_n (rst_n),
        .req   (ent.done),
        .gnt   (gnt)
    );

    assign ent.cdb_gnt = gnt;
    assign cdb_valid   = |gnt;

    always_comb begin
        raw       = '0;
        size      = sz_byte;
        is_signed = 1'b0;
        cdb_prf   = '0;
        cdb_rob   = '0;
        for (int e = 0; e < lq_depth; e++) begin
            if (gnt[e]) begin
                raw       = ent.data[e];
                size      = ent.size[e];
                is_signed = ent.is_signed[e];
                cdb_prf   = ent.prf[e];
                cdb_rob   = ent.rob[e];
            end
        end
    end

    // sign extension for narrow signed loads only
    always_comb begin
        cdb_data = raw;
        if (is_signed) begin
            case (size)
                sz_byte: cdb_data = {{(data_w-8){raw[7]}}, raw[7:0]};
                sz_half: cdb_data = {{(data_w-16){raw[15]}}, raw[15:0]};
                default: cdb_data = raw;
            endcase
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the load queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_load_queue -o tb_load_queue
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/tb_load_queue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1

// File: tb_load_queue.sv
`timescale 1ns/1ps

module tb_load_queue;
    import lq_pkg::*;

    localparam int n_loads    = 300;
    localparam int max_cycles = 20000;
    localparam int load_limit = 500;
    localparam int n_rob      = 1 << rob_w;

    logic                            clock;
    logic                            rst_n;
    logic [ways-1:0]                 ld_en;
    ld_size_t [ways-1:0]             ld_size;
    logic [ways-1:0][rob_w-1:0]      ld_rob;
    logic [ways-1:0][prf_w-1:0]      ld_prf;
    logic [ways-1:0]                 ld_signed;
    logic [ways-1:0]                 alu_valid;
    logic [ways-1:0]                 alu_is_ls;
    logic [ways-1:0][rob_w-1:0]      alu_rob;
    logic [ways-1:0][addr_w-1:0]     alu_data;
    logic                            dc_hit;
    logic [data_w-1:0]               dc_data;
    logic [lq_depth-1:0]             mem_feedback;
    logic [data_w-1:0]               mem_data;
    logic [cnt_w-1:0]                lq_num_free;
    logic                            rd_en;
    logic [lq_depth-1:0]             rd_gnt;
    logic [tag_w-1:0]                rd_tag;
    logic [index_w-1:0]              rd_idx;
    logic [offset_w-1:0]             rd_offset;
    ld_size_t                        rd_size;
    logic                            cdb_valid;
    logic [data_w-1:0]               cdb_data;
    logic [prf_w-1:0]                cdb_prf;
    logic [rob_w-1:0]                cdb_rob;

    // model of outstanding loads by ROB index
    logic              pend [n_rob];
    logic              alu_sent [n_rob];
    logic              missed [n_rob];
    logic [prf_w-1:0]  prf_of [n_rob];
    logic [1:0]        size_of [n_rob];
    logic              sgn_of [n_rob];
    logic [addr_w-1:0] addr_of [n_rob];
    int                alu_due [n_rob];
    int                disp_cycle [n_rob];

    // model of queue entries
    logic              busy [lq_depth];
    logic [rob_w-1:0]  ent_rob [lq_depth];
    logic              filling [lq_depth];
    int                fill_due [lq_depth];

    logic [31:0]       rng;
    logic [rob_w-1:0]  next_rob;
    int                errors;
    int                n_checks;
    int                cycle;
    int                issued;
    int                retired;

    load_queue DUT (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // cache line and memory fill contents from the full address
    function automatic logic [31:0] hit_word(input logic [addr_w-1:0] a);
        return {a ^ 16'hc3a5, a[7:0], a[15:8]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [addr_w-1:0] a);
        return {a[3:0], a, ~a[15:4]} ^ 32'h8001_7ff0;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [31:0] w, input logic [1:0] sz,
                                                input logic sgn);
        if (sgn && sz == 2'd0) begin
            return {{24{w[7]}}, w[7:0]};
        end
        if (sgn && sz == 2'd1) begin
            return {{16{w[15]}}, w[15:0]};
        end
        return w;
    endfunction

    // free entries as reported with the clamp below a full dispatch group
    function automatic int expected_free();
        int n;
        n = 0;
        for (int e = 0; e < lq_depth; e++) begin
            if (!busy[e]) begin
                n++;
            end
        end
        return (n < ways) ? 0 : n;
    endfunction

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string what);
        n_checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %0d ns: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    task automatic idle_inputs();
        ld_en        = '0;
        ld_rob       = '0;
        ld_prf       = '0;
        ld_signed    = '0;
        alu_valid    = '0;
        alu_is_ls    = '0;
        alu_rob      = '0;
        alu_data     = '0;
        dc_hit       = 1'b0;
        dc_data      = '0;
        mem_feedback = '0;
        mem_data     = '0;
        for (int w = 0; w < ways; w++) begin
            ld_size[w] = sz_byte;
        end
    endtask

    task automatic answer_cache();
        int                e;
        logic [rob_w-1:0]  r;
        logic [31:0]       rv;
        logic [addr_w-1:0] a;
        dc_hit  = 1'b0;
        dc_data = '0;
        if (rd_en) begin
            e = 0;
            for (int i = 0; i < lq_depth; i++) begin
                if (rd_gnt[i]) begin
                    e = i;
                end
            end
            r = ent_rob[e];
            a = {rd_tag, rd_idx, rd_offset};
            check(32'd1, 32'(busy[e]), $sformatf("read grant on entry %0d", e));
            check(32'(addr_of[r]), 32'(a), $sformatf("read address of ROB %0d", r));
            check(32'(size_of[r]), 32'(rd_size), $sformatf("read size of ROB %0d", r));
            rv      = next_rand();
            dc_hit  = rv[3];
            dc_data = hit_word(a);
            if (!rv[3]) begin
                missed[r]   = 1'b1;
                filling[e]  = 1'b1;
                fill_due[e] = cycle + 2 + int'(rv[31:8] % 24'd5);
            end
        end
    endtask

    // one fill per cycle at the entry position seen on the miss
    task automatic answer_fill();
        mem_feedback = '0;
        mem_data     = '0;
        for (int e = 0; e < lq_depth; e++) begin
            if (filling[e] && fill_due[e] <= cycle && mem_feedback == '0) begin
                mem_feedback[e] = 1'b1;
                mem_data        = fill_word(addr_of[ent_rob[e]]);
                filling[e]      = 1'b0;
            end
        end
    endtask

    task automatic drive_alu();
        int          w;
        logic [31:0] rv;
        w         = 0;
        alu_valid = '0;
        alu_is_ls = '0;
        alu_rob   = '0;
        alu_data  = '0;
        for (int r = 0; r < n_rob; r++) begin
            if (w < ways && pend[r] && !alu_sent[r] && alu_due[r] <= cycle) begin
                alu_valid[w] = 1'b1;
                alu_is_ls[w] = 1'b1;
                alu_rob[w]   = rob_w'(r);
                alu_data[w]  = addr_of[r];
                alu_sent[r]  = 1'b1;
                w++;
            end
        end
        // idle ways carry no result or a non-memory result that the queue must ignore
        for (int i = w; i < ways; i++) begin
            rv           = next_rand();
            alu_valid[i] = rv[0];
            alu_is_ls[i] = !rv[0] && rv[1];
            alu_rob[i]   = rv[8:4];
            alu_data[i]  = rv[31:16];
        end
    endtask

    task automatic take_cdb(output int rel);
        logic [rob_w-1:0] r;
        logic [31:0]      word;
        rel = -1;
        if (cdb_valid) begin
            r = cdb_rob;
            if (!pend[r]) begin
                errors++;
                $display("ROB %0d was broadcast on the CDB while not outstanding", r);
            end else begin
                check(32'(prf_of[r]), 32'(cdb_prf), $sformatf("CDB PRF of ROB %0d", r));
                word = missed[r] ? fill_word(addr_of[r]) : hit_word(addr_of[r]);
                check(sign_extend(word, size_of[r], sgn_of[r]), cdb_data,
                      $sformatf("CDB data of ROB %0d", r));
                pend[r] = 1'b0;
                retired++;
                for (int e = 0; e < lq_depth; e++) begin
                    if (busy[e] && ent_rob[e] == r) begin
                        rel = e;
                    end
                end
            end
        end
    endtask

    task automatic dispatch_loads();
        int          e0;
        int          e;
        logic [31:0] rv;
        logic [31:0] rv2;
        logic [1:0]  sz;
        e0        = -1;
        ld_en     = '0;
        ld_rob    = '0;
        ld_prf    = '0;
        ld_signed = '0;
        for (int w = 0; w < ways; w++) begin
            ld_size[w] = sz_byte;
        end
        if (lq_num_free >= cnt_w'(ways)) begin
            for (int w = 0; w < ways; w++) begin
                rv = next_rand();
                if (rv[0] && issued < n_loads && !pend[next_rob]) begin
                    // way 0 keeps the lowest free entry and way 1 the highest
                    e = -1;
                    for (int i = 0; i < lq_depth; i++) begin
                        if (!busy[i] && i != e0 && (w != 0 || e < 0)) begin
                            e = i;
                        end
                    end
                    if (e >= 0) begin
                        rv2          = next_rand();
                        sz           = 2'(rv[31:16] % 16'd3);
                        e0           = (w == 0) ? e : e0;
                        busy[e]      = 1'b1;
                        ent_rob[e]   = next_rob;
                        filling[e]   = 1'b0;
                        ld_en[w]     = 1'b1;
                        ld_rob[w]    = next_rob;
                        ld_prf[w]    = rv[9:4];
                        ld_size[w]   = ld_size_t'(sz);
                        ld_signed[w] = rv[1];
                        pend[next_rob]       = 1'b1;
                        alu_sent[next_rob]   = 1'b0;
                        missed[next_rob]     = 1'b0;
                        prf_of[next_rob]     = rv[9:4];
                        size_of[next_rob]    = sz;
                        sgn_of[next_rob]     = rv[1];
                        addr_of[next_rob]    = rv2[15:0];
                        alu_due[next_rob]    = cycle + 1 + int'(rv2[17:16]);
                        disp_cycle[next_rob] = cycle;
                        next_rob = next_rob + 1'b1;
                        issued++;
                    end
                end
            end
        end
    endtask

    task automatic watch_ages();
        for (int r = 0; r < n_rob; r++) begin
            if (pend[r] && cycle - disp_cycle[r] > load_limit) begin
                errors++;
                $display("load with ROB %0d was not broadcast within %0d cycles", r, load_limit);
                pend[r] = 1'b0;
                retired++;
            end
        end
    endtask

    initial begin
        int rel;
        rng      = 32'h7e02_a1ec;
        next_rob = '0;
        errors   = 0;
        n_checks = 0;
        cycle    = 0;
        issued   = 0;
        retired  = 0;
        for (int r = 0; r < n_rob; r++) begin
            pend[r]     = 1'b0;
            alu_sent[r] = 1'b0;
            missed[r]   = 1'b0;
        end
        for (int e = 0; e < lq_depth; e++) begin
            busy[e]    = 1'b0;
            ent_rob[e] = '0;
            filling[e] = 1'b0;
            fill_due[e] = 0;
        end
        idle_inputs();
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check(32'd0, 32'(rd_en), "rd_en after reset");
        check(32'd0, 32'(cdb_valid), "cdb_valid after reset");
        check(32'(lq_depth), 32'(lq_num_free), "lq_num_free after reset");

        // release of a broadcast entry lands after this cycle's allocation
        while ((issued < n_loads || retired < issued) && cycle < max_cycles) begin
            @(negedge clock);
            cycle++;
            check(32'(expected_free()), 32'(lq_num_free), "lq_num_free");
            answer_cache();
            answer_fill();
            drive_alu();
            take_cdb(rel);
            dispatch_loads();
            if (rel >= 0) begin
                busy[rel] = 1'b0;
            end
            watch_ages();
        end

        if (issued < n_loads || retired < issued) begin
            errors++;
            $display("timed out after %0d cycles with %0d of %0d loads retired",
                     cycle, retired, n_loads);
        end
        $display("%0d loads, %0d checks, %0d errors", retired, n_checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
